// File: pad_pkg.sv
package pad_pkg;

    ////////////////////
    // sizes
    ////////////////////

    // one channel value
    localparam int data_w = 8;
    // channel values per beat
    localparam int lanes = 4;
    // row and column count of the input map
    localparam int size_w = 6;
    localparam int grp_w = 4;
    localparam int zero_w = 3;

    // output map size, up to 63 + 2*7
    localparam int osize_w = 8;
    // row beat count, N*G
    localparam int beats_w = size_w + grp_w;

    localparam int fifo_depth = 256;
    localparam int fifo_aw = 8;
    localparam int cnt_w = fifo_aw + 1;

    ////////////////////
    // wishbone map
    ////////////////////

    localparam int adr_w = 3;
    localparam int wb_dw = 32;

    localparam logic [adr_w-1:0] reg_size = 3'd0;
    localparam logic [adr_w-1:0] reg_grp = 3'd1;
    localparam logic [adr_w-1:0] reg_pad = 3'd2;
    localparam logic [adr_w-1:0] reg_zp = 3'd3;
    localparam logic [adr_w-1:0] reg_ctrl = 3'd4;
    localparam logic [adr_w-1:0] reg_stat = 3'd5;

    ////////////////////
    // types
    ////////////////////

    typedef logic [lanes-1:0][data_w-1:0] lane_vec_t;

    typedef struct packed {
        logic [size_w-1:0] row_num;
        logic [grp_w-1:0]  ch_groups;
        logic              pad_en;
        logic [zero_w-1:0] zero_num;
        logic [data_w-1:0] zero_point;
    } pad_cfg_t;

    // one output beat request from the controller
    typedef struct packed {
        logic sel_zero;
        logic row_end;
        logic frame_end;
    } pad_cmd_t;

    typedef struct packed {
        lane_vec_t data;
        logic      row_end;
        logic      frame_end;
    } pad_beat_t;

endpackage

// File: pad_csr.sv
module pad_csr (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        wb_cyc,
    input  logic                        wb_stb,
    input  logic                        wb_we,
    input  logic [pad_pkg::adr_w-1:0]   wb_adr,
    input  logic [pad_pkg::wb_dw-1:0]   wb_dat_w,
    input  logic                        busy,
    input  logic [pad_pkg::osize_w-1:0] out_size,
    output logic [pad_pkg::wb_dw-1:0]   wb_dat_r,
    output logic                        wb_ack,
    output pad_pkg::pad_cfg_t           cfg,
    output logic                        start
);
    import pad_pkg::*;

    // set once a request has been acked, cleared when stb drops
    logic served;
    logic wr_hit;

    assign wr_hit = wb_ack && wb_we;

    ////////////////////
    // bus handshake
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack <= 1'b0;
            served <= 1'b0;
        end else begin
            wb_ack <= wb_cyc && wb_stb && !wb_ack && !served;
            if (!(wb_cyc && wb_stb)) begin
                served <= 1'b0;
            end else if (wb_ack) begin
                served <= 1'b1;
            end
        end
    end

    ////////////////////
    // registers
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg <= '0;
        end else if (wr_hit) begin
            case (wb_adr)
                reg_size: cfg.row_num <= wb_dat_w[size_w-1:0];
                reg_grp:  cfg.ch_groups <= wb_dat_w[grp_w-1:0];
                reg_pad: begin
                    cfg.pad_en <= wb_dat_w[0];
                    cfg.zero_num <= wb_dat_w[zero_w:1];
                end
                reg_zp:   cfg.zero_point <= wb_dat_w[data_w-1:0];
                default: ;
            endcase
        end
    end

    // start lands one cycle after the ack, dropped while a frame runs
    always_ff @(posedge clk) begin
        if (rst) begin
            start <= 1'b0;
        end else begin
            start <= wr_hit && (wb_adr == reg_ctrl) && wb_dat_w[0] && !busy;
        end
    end

    always_comb begin
        case (wb_adr)
            reg_size: wb_dat_r = wb_dw'(cfg.row_num);
            reg_grp:  wb_dat_r = wb_dw'(cfg.ch_groups);
            reg_pad:  wb_dat_r = wb_dw'({cfg.zero_num, cfg.pad_en});
            reg_zp:   wb_dat_r = wb_dw'(cfg.zero_point);
            reg_stat: wb_dat_r = wb_dw'({out_size, busy});
            default:  wb_dat_r = '0;
        endcase
    end

    a_ack_single: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
        else $error("wb_ack held for two cycles");

endmodule

// File: pad_row_fifo.sv
module pad_row_fifo (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wr_en,
    input  pad_pkg::lane_vec_t        din,
    input  logic                      rd_en,
    output pad_pkg::lane_vec_t        dout,
    output logic [pad_pkg::cnt_w-1:0] count,
    output logic                      full
);
    import pad_pkg::*;

    lane_vec_t mem [fifo_depth];

    logic [fifo_aw-1:0] wr_ptr;
    logic [fifo_aw-1:0] rd_ptr;

    ////////////////////
    // storage
    ////////////////////

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= din;
        end
    end

    // head word visible without a read cycle
    assign dout = mem[rd_ptr];

    ////////////////////
    // pointers
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign full = (count == cnt_w'(fifo_depth));

    a_no_overflow: assert property (@(posedge clk) disable iff (rst) wr_en |-> !full)
        else $error("fifo written while full");

    a_no_underflow: assert property (@(posedge clk) disable iff (rst) rd_en |-> count != 0)
        else $error("fifo read while empty");

endmodule

// File: pad_ctrl.sv
module pad_ctrl (
    input  logic                        clk,
    input  logic                        rst,
    input  pad_pkg::pad_cfg_t           cfg,
    input  logic                        start,
    input  logic [pad_pkg::cnt_w-1:0]   fifo_count,
    input  logic                        cmd_ready,
    output logic                        fifo_rd,
    output logic                        cmd_valid,
    output pad_pkg::pad_cmd_t           cmd,
    output logic                        busy,
    output logic                        done,
    output logic [pad_pkg::osize_w-1:0] out_size
);
    import pad_pkg::*;

    typedef enum logic [2:0] {
        idle, setup, row_wait, emit_left, emit_data, emit_right, emit_border, next_row
    } state_t;

    state_t state;

    // frame settings held for the whole frame
    logic [size_w-1:0]  n_q;
    logic [grp_w-1:0]   g_q;
    logic [zero_w-1:0]  zeff;
    logic [osize_w-1:0] m_size;
    logic [beats_w-1:0] row_beats;

    logic [grp_w-1:0]   grp_cnt;
    logic [osize_w-1:0] col_cnt;
    logic [osize_w-1:0] row_cnt;
    logic [osize_w-1:0] row_nxt;
    logic [osize_w-1:0] seg_len;

    logic last_grp;
    logic last_col;
    logic beat_last;
    logic last_row;
    logic row_end_beat;
    logic nxt_border;
    logic accept;

    ////////////////////
    // beat position
    ////////////////////

    always_comb begin
        case (state)
            emit_border: seg_len = m_size;
            emit_data:   seg_len = osize_w'(n_q);
            default:     seg_len = osize_w'(zeff);
        endcase
    end

    assign last_grp = (grp_cnt == g_q - 1'b1);
    assign last_col = (col_cnt == seg_len - 1'b1);
    assign beat_last = last_grp && last_col;
    assign last_row = (row_cnt == m_size - 1'b1);

    // row_cnt starts at all ones so the first next_row lands on row 0
    assign row_nxt = row_cnt + 1'b1;
    assign nxt_border = (row_nxt < osize_w'(zeff)) || (row_nxt >= m_size - osize_w'(zeff));

    assign row_end_beat = beat_last && ((state == emit_border) || (state == emit_right) ||
                                        ((state == emit_data) && (zeff == '0)));

    assign cmd_valid = (state == emit_left) || (state == emit_data) ||
                       (state == emit_right) || (state == emit_border);
    assign cmd.sel_zero = (state != emit_data);
    assign cmd.row_end = row_end_beat;
    assign cmd.frame_end = row_end_beat && last_row;

    assign accept = cmd_valid && cmd_ready;
    assign fifo_rd = accept && (state == emit_data);
    assign busy = (state != idle);
    assign out_size = m_size;

    ////////////////////
    // fsm and counters
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            n_q <= '0;
            g_q <= '0;
            zeff <= '0;
            m_size <= '0;
            row_beats <= '0;
            grp_cnt <= '0;
            col_cnt <= '0;
            row_cnt <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                idle: begin
                    if (start) begin
                        n_q <= cfg.row_num;
                        g_q <= cfg.ch_groups;
                        zeff <= cfg.pad_en ? cfg.zero_num : '0;
                        state <= setup;
                    end
                end
                setup: begin
                    m_size <= osize_w'(n_q) + osize_w'({zeff, 1'b0});
                    row_beats <= beats_w'(n_q) * beats_w'(g_q);
                    row_cnt <= '1;
                    state <= next_row;
                end
                next_row: begin
                    row_cnt <= row_nxt;
                    grp_cnt <= '0;
                    col_cnt <= '0;
                    state <= nxt_border ? emit_border : row_wait;
                end
                row_wait: begin
                    // whole input row must be buffered first
                    if (beats_w'(fifo_count) >= row_beats) begin
                        state <= (zeff != '0) ? emit_left : emit_data;
                    end
                end
                default: begin
                    if (accept) begin
                        grp_cnt <= last_grp ? '0 : grp_cnt + 1'b1;
                        if (last_grp) begin
                            col_cnt <= last_col ? '0 : col_cnt + 1'b1;
                        end
                        if (beat_last) begin
                            if (state == emit_left) begin
                                state <= emit_data;
                            end else if ((state == emit_data) && (zeff != '0)) begin
                                state <= emit_right;
                            end else if (last_row) begin
                                state <= idle;
                                done <= 1'b1;
                            end else begin
                                state <= next_row;
                            end
                        end
                    end
                end
            endcase
        end
    end

    a_pop_with_data: assert property (@(posedge clk) disable iff (rst)
        fifo_rd |-> cmd_valid && cmd_ready && !cmd.sel_zero && (fifo_count != '0))
        else $error("fifo pop without an accepted data command");

endmodule

// File: pad_out_stage.sv
module pad_out_stage (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cmd_valid,
    input  pad_pkg::pad_cmd_t          cmd,
    input  pad_pkg::lane_vec_t         fifo_dout,
    input  logic [pad_pkg::data_w-1:0] zero_point,
    input  logic                       out_ready,
    output logic                       cmd_ready,
    output logic                       out_valid,
    output pad_pkg::pad_beat_t         out_beat
);
    import pad_pkg::*;

    // two entries, buf0 is the head shown on the port
    pad_beat_t buf0;
    pad_beat_t buf1;
    logic [1:0] fill;

    pad_beat_t new_beat;
    lane_vec_t zero_vec;
    logic push;
    logic pop;

    ////////////////////
    // beat build
    ////////////////////

    assign zero_vec = {lanes{zero_point}};

    assign new_beat.data = cmd.sel_zero ? zero_vec : fifo_dout;
    assign new_beat.row_end = cmd.row_end;
    assign new_beat.frame_end = cmd.frame_end;

    assign cmd_ready = (fill != 2'd2);
    assign out_valid = (fill != 2'd0);
    assign out_beat = buf0;

    assign push = cmd_valid && cmd_ready;
    assign pop = out_valid && out_ready;

    ////////////////////
    // skid buffer
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            fill <= 2'd0;
        end else begin
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push && !pop) begin
            if (fill == 2'd0) begin
                buf0 <= new_beat;
            end else begin
                buf1 <= new_beat;
            end
        end else if (pop && !push) begin
            buf0 <= buf1;
        end else if (push && pop) begin
            // only reachable with one entry held
            buf0 <= new_beat;
        end
    end

    a_hold_stable: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_beat))
        else $error("out_beat changed while stalled");

endmodule

// File: pad_top.sv
module pad_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  logic [pad_pkg::adr_w-1:0] wb_adr,
    input  logic [pad_pkg::wb_dw-1:0] wb_dat_w,
    output logic [pad_pkg::wb_dw-1:0] wb_dat_r,
    output logic                      wb_ack,
    input  logic                      in_valid,
    input  pad_pkg::lane_vec_t        in_data,
    output logic                      in_ready,
    output logic                      out_valid,
    output pad_pkg::pad_beat_t        out_beat,
    input  logic                      out_ready,
    output logic                      done
);
    import pad_pkg::*;

    pad_cfg_t cfg;
    pad_cmd_t cmd;
    lane_vec_t fifo_dout;
    logic [cnt_w-1:0] fifo_count;
    logic [osize_w-1:0] out_size;
    logic fifo_full;
    logic fifo_rd;
    logic start;
    logic busy;
    logic cmd_valid;
    logic cmd_ready;

    assign in_ready = !fifo_full;

    pad_csr u_csr (
        .clk(clk), .rst(rst),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
        .busy(busy), .out_size(out_size),
        .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .cfg(cfg), .start(start)
    );

    pad_row_fifo u_fifo (
        .clk(clk), .rst(rst),
        .wr_en(in_valid && in_ready), .din(in_data), .rd_en(fifo_rd),
        .dout(fifo_dout), .count(fifo_count), .full(fifo_full)
    );

    pad_ctrl u_ctrl (
        .clk(clk), .rst(rst),
        .cfg(cfg), .start(start), .fifo_count(fifo_count), .cmd_ready(cmd_ready),
        .fifo_rd(fifo_rd), .cmd_valid(cmd_valid), .cmd(cmd),
        .busy(busy), .done(done), .out_size(out_size)
    );

    pad_out_stage u_out (
        .clk(clk), .rst(rst),
        .cmd_valid(cmd_valid), .cmd(cmd), .fifo_dout(fifo_dout),
        .zero_point(cfg.zero_point), .out_ready(out_ready),
        .cmd_ready(cmd_ready), .out_valid(out_valid), .out_beat(out_beat)
    );

endmodule

// File: tb_pad_top.sv
module tb_pad_top;
    timeunit 1ns;
    timeprecision 1ps;
    import pad_pkg::*;

    // output beats summed over all frames at M*M*G each
    localparam int beat_sum = 4*4*2 + 7*7*2 + 9*9*2 + 9*9*2 + 6*6*2;
    localparam int watch_ns = 40 * 4 * beat_sum + 40 * 600;

    logic clk;
    logic rst;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    logic [adr_w-1:0] wb_adr;
    logic [wb_dw-1:0] wb_dat_w;
    logic [wb_dw-1:0] wb_dat_r;
    logic wb_ack;
    logic in_valid;
    lane_vec_t in_data;
    logic in_ready;
    logic out_valid;
    pad_beat_t out_beat;
    logic out_ready;
    logic done;

    lane_vec_t in_q[$];
    pad_beat_t exp_q[$];
    pad_beat_t exp_b;
    bit rnd_ready = 1'b0;
    int err_cnt = 0;
    int beat_cnt = 0;
    int done_cnt = 0;
    int test_cnt = 0;
    int fail_cnt = 0;

    pad_top DUT (
        .clk(clk), .rst(rst),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .in_valid(in_valid), .in_data(in_data), .in_ready(in_ready),
        .out_valid(out_valid), .out_beat(out_beat), .out_ready(out_ready), .done(done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////
    // bus and stream drivers
    ////////////////////

    // one wishbone cycle with stb held for hold extra cycles after the ack
    task automatic wb_xfer(input bit we, input logic [adr_w-1:0] adr,
                           input logic [wb_dw-1:0] wdat, input int hold,
                           output logic [wb_dw-1:0] rdat);
        int acks;
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= we;
        wb_adr <= adr;
        wb_dat_w <= wdat;
        @(negedge clk);
        while (!wb_ack) @(negedge clk);
        rdat = wb_dat_r;
        acks = 0;
        repeat (hold) begin
            @(negedge clk);
            if (wb_ack) acks++;
        end
        assert (acks == 0) else begin
            $display("[FAIL] %0t: %0d extra acks while stb held", $time, acks);
            err_cnt++;
        end
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we <= 1'b0;
    endtask

    task automatic drive_input(input bit gaps);
        lane_vec_t w;
        bit taken;
        while (in_q.size() > 0) begin
            w = in_q.pop_front();
            if (gaps) begin
                repeat ($urandom_range(0, 2)) begin
                    @(posedge clk);
                    in_valid <= 1'b0;
                end
            end
            @(posedge clk);
            in_valid <= 1'b1;
            in_data <= w;
            taken = 1'b0;
            while (!taken) begin
                @(negedge clk);
                taken = in_ready;
                if (!taken) @(posedge clk);
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    initial begin
        out_ready = 1'b0;
        forever begin
            @(posedge clk);
            out_ready <= rnd_ready ? 1'($urandom_range(0, 1)) : 1'b1;
        end
    end

    ////////////////////
    // reference model
    ////////////////////

    // expected output in row, column and group order
    // interior beats take fresh input words
    task automatic build_frame(input int n, input int g, input int z, input logic [7:0] zp);
        int m;
        lane_vec_t w;
        pad_beat_t b;
        m = n + 2 * z;
        for (int r = 0; r < m; r++) begin
            for (int c = 0; c < m; c++) begin
                for (int k = 0; k < g; k++) begin
                    if (r < z || r >= m - z || c < z || c >= m - z) begin
                        b.data = {lanes{zp}};
                    end else begin
                        w = lane_vec_t'($urandom);
                        in_q.push_back(w);
                        b.data = w;
                    end
                    b.row_end = (c == m - 1) && (k == g - 1);
                    b.frame_end = b.row_end && (r == m - 1);
                    exp_q.push_back(b);
                end
            end
        end
    endtask

    always @(negedge clk) begin
        if (!rst && done) done_cnt++;
        if (!rst && out_valid && out_ready) begin
            beat_cnt++;
            if (exp_q.size() == 0) begin
                $display("output beat at %0t arrived with none expected", $time);
                err_cnt++;
            end else begin
                exp_b = exp_q.pop_front();
                assert (out_beat == exp_b) else begin
                    $display("[FAIL] %0t: beat %0d is %h, expected %h",
                             $time, beat_cnt, out_beat, exp_b);
                    err_cnt++;
                end
            end
        end
    end

    a_stall_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_beat))
        else begin
            $display("[FAIL] %0t: out_beat moved while stalled", $time);
            err_cnt++;
        end

    a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else begin
            $display("[FAIL] %0t: done longer than one cycle", $time);
            err_cnt++;
        end

    a_frame_on_row: assert property (@(posedge clk) disable iff (rst)
        out_valid && out_beat.frame_end |-> out_beat.row_end)
        else begin
            $display("[FAIL] %0t: frame_end without row_end", $time);
            err_cnt++;
        end

    a_ack_on_req: assert property (@(posedge clk) disable iff (rst)
        $rose(wb_ack) |-> $past(wb_cyc && wb_stb))
        else begin
            $display("[FAIL] %0t: wb_ack without a request", $time);
            err_cnt++;
        end

    // no test buffers more than one frame of input, far below fifo_depth
    a_in_ready: assert property (@(posedge clk) disable iff (rst) in_ready)
        else begin
            $display("[FAIL] %0t: in_ready low while the fifo cannot be full", $time);
            err_cnt++;
        end

    ////////////////////
    // tests
    ////////////////////

    task automatic report(input string name, input int err0);
        test_cnt++;
        if (err_cnt != err0) fail_cnt++;
        $display("test %0d %s: %s", test_cnt, name, (err_cnt == err0) ? "ok" : "errors");
    endtask

    task automatic check_regs();
        logic [adr_w-1:0] adrs[4];
        logic [wb_dw-1:0] vals[4];
        logic [wb_dw-1:0] rd;
        int err0;
        err0 = err_cnt;
        adrs = '{reg_size, reg_grp, reg_pad, reg_zp};
        vals = '{32'd45, 32'd7, 32'h0b, 32'h9c};
        for (int i = 0; i < 4; i++) wb_xfer(1'b1, adrs[i], vals[i], 0, rd);
        for (int i = 0; i < 4; i++) begin
            wb_xfer(1'b0, adrs[i], '0, 3, rd);
            assert (rd == vals[i]) else begin
                $display("[FAIL] %0t: reg %0d reads %h, wrote %h", $time, adrs[i], rd, vals[i]);
                err_cnt++;
            end
        end
        wb_xfer(1'b0, reg_stat, '0, 0, rd);
        assert (rd[0] == 1'b0) else begin
            $display("[FAIL] %0t: busy set before any start", $time);
            err_cnt++;
        end
        report("register readback", err0);
    endtask

    task automatic run_frame(input string name, input int n, input int g, input int pen,
                             input int z, input logic [7:0] zp, input bit rnd, input bit dbl);
        int m;
        int ze;
        int err0;
        logic [wb_dw-1:0] rd;
        err0 = err_cnt;
        ze = pen ? z : 0;
        m = n + 2 * ze;
        build_frame(n, g, ze, zp);
        beat_cnt = 0;
        done_cnt = 0;
        rnd_ready = rnd;
        wb_xfer(1'b1, reg_size, n, 0, rd);
        wb_xfer(1'b1, reg_grp, g, 0, rd);
        wb_xfer(1'b1, reg_pad, (z << 1) | pen, 0, rd);
        wb_xfer(1'b1, reg_zp, zp, 0, rd);
        wb_xfer(1'b1, reg_ctrl, 1, 0, rd);
        fork
            drive_input(rnd);
            begin
                if (dbl) begin
                    wb_xfer(1'b0, reg_stat, '0, 0, rd);
                    assert (rd[0]) else begin
                        $display("[FAIL] %0t: busy low right after start", $time);
                        err_cnt++;
                    end
                    // second start lands mid frame
                    wb_xfer(1'b1, reg_ctrl, 1, 0, rd);
                end
                while (done_cnt == 0 || exp_q.size() != 0) @(negedge clk);
            end
        join
        repeat (20) @(posedge clk);
        wb_xfer(1'b0, reg_stat, '0, 0, rd);
        assert (rd[0] == 1'b0 && rd[8:1] == m[7:0]) else begin
            $display("[FAIL] %0t: status %h, expected idle with size %0d", $time, rd, m);
            err_cnt++;
        end
        assert (done_cnt == 1 && beat_cnt == m * m * g) else begin
            $display("[FAIL] %0t: %0d done pulses and %0d beats, expected 1 and %0d",
                     $time, done_cnt, beat_cnt, m * m * g);
            err_cnt++;
        end
        rnd_ready = 1'b0;
        report(name, err0);
    endtask

    initial begin
        void'($urandom(32'h728d_5166));
        rst = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        in_valid = 1'b0;
        in_data = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);
        check_regs();
        run_frame("no padding", 4, 2, 0, 3, 8'h11, 1'b0, 1'b0);
        run_frame("pad width 1", 5, 2, 1, 1, 8'h80, 1'b0, 1'b0);
        run_frame("pad width 2", 5, 2, 1, 2, 8'h7f, 1'b0, 1'b0);
        run_frame("pad width 2 with stalls", 5, 2, 1, 2, 8'h7f, 1'b1, 1'b0);
        run_frame("start while busy", 4, 2, 1, 1, 8'h05, 1'b0, 1'b1);
        $display("%0d tests, %0d failed, %0d check errors", test_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0 && fail_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(watch_ns);
        $display("run timed out after %0d ns", watch_ns);
        $display("Test failed");
        $finish;
    end

endmodule

// File: vlog.f
pad_pkg.sv
pad_csr.sv
pad_row_fifo.sv
pad_ctrl.sv
pad_out_stage.sv
pad_top.sv
tb_pad_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the padding engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    -f vlog.f --top-module tb_pad_top > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/Vtb_pad_top > sim.log 2>&1 \
    || echo "Test failed: simulator exited abnormally" >> sim.log

cat sim.log

grep -q "Test failed" sim.log \
    && { echo "simulation FAILED"; exit 1; } \
    || { echo "simulation PASSED"; exit 0; }
